//--- aes_pkg.sv
// ======================================
// shared AES-128 types, constants and byte functions
// key size is fixed at 128 bits, ten rounds
// S-box tables are constants and synthesize to ROM or logic
// byte 0 of a block sits in bits [127:120]
// ======================================

`default_nettype none

package aes_pkg;

  // ======================================
  // sizes
  // ======================================
  localparam int BLOCK_W = 128;
  localparam int NUM_BYTES = BLOCK_W / 8;
  localparam int ROUND_W = 4;
  localparam logic [ROUND_W-1:0] NUM_ROUNDS = 4'd10;
  localparam int NUM_ROUND_KEYS = 11;

  // ======================================
  // types
  // ======================================
  // cipher direction, encoding follows the mode pin
  typedef enum logic {
    AES_DECRYPT = 1'b0,
    AES_ENCRYPT = 1'b1
  } aes_mode_e;

  // job latched by the core on init
  typedef struct packed {
    aes_mode_e mode;
    logic [BLOCK_W-1:0] data;
  } aes_job_t;

  // top level sequencer
  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_EXPAND,
    CORE_CIPHER
  } aes_core_state_e;

  // ======================================
  // substitution tables
  // ======================================
  // entry 0 is leftmost
  localparam logic [0:255][7:0] SBOX_LUT = {
    128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
  };

  localparam logic [0:255][7:0] INV_SBOX_LUT = {
    128'h52096ad53036a538bf40a39e81f3d7fb, 128'h7ce339829b2fff87348e4344c4dee9cb,
    128'h547b9432a6c2233dee4c950b42fac34e, 128'h082ea16628d924b2765ba2496d8bd125,
    128'h72f8f66486689816d4a45ccc5d65b692, 128'h6c704850fdedb9da5e154657a78d9d84,
    128'h90d8ab008cbcd30af7e45805b8b34506, 128'hd02c1e8fca3f0f02c1afbd0301138a6b,
    128'h3a9111414f67dcea97f2cfcef0b4e673, 128'h96ac7422e7ad3585e2f937e81c75df6e,
    128'h47f11a711d29c5896fb7620eaa18be1b, 128'hfc563e4bc6d279209adbc0fe78cd5af4,
    128'h1fdda8338807c731b11210592780ec5f, 128'h60517fa919b54a0d2de57a9f93c99cef,
    128'ha0e03b4dae2af5b0c8ebbb3c83539961, 128'h172b047eba77d626e169146355210c7d
  };

  // ======================================
  // byte functions
  // ======================================
  function automatic logic [7:0] sbox(input logic [7:0] b);
    return SBOX_LUT[b];
  endfunction

  function automatic logic [7:0] inv_sbox(input logic [7:0] b);
    return INV_SBOX_LUT[b];
  endfunction

  // multiply by x modulo x^8+x^4+x^3+x+1
  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // shift-and-add product in GF(2^8)
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ p;
      end
      p = xtime(p);
    end
    return acc;
  endfunction

endpackage

`default_nettype wire

//--- aes_key_memory.sv
// ======================================
// AES-128 key schedule into eleven round-key registers
// one key per cycle, key 0 on the init edge, key 10 ten edges later
// read port is combinational, index must stay within 0..10
// a new init restarts expansion from the cipher key
// ======================================

`timescale 1ns/10ps
`default_nettype none

module aes_key_memory (
  input wire clk_in,
  input wire rst_in,
  input wire init_in,
  input wire [aes_pkg::BLOCK_W-1:0] key_in,
  input wire [aes_pkg::ROUND_W-1:0] round_rd,
  output logic [aes_pkg::BLOCK_W-1:0] key_out,
  output logic key_expanded_out
);

  // round key file
  logic [aes_pkg::BLOCK_W-1:0] rk_q [aes_pkg::NUM_ROUND_KEYS];
  // last key written, feeds the next step
  logic [aes_pkg::BLOCK_W-1:0] prev_q;
  logic [aes_pkg::BLOCK_W-1:0] next_key;
  logic [7:0] rcon_q;
  logic [aes_pkg::ROUND_W-1:0] cnt_q;
  logic busy_q;

  // ======================================
  // one expansion step
  // ======================================
  always_comb begin
    logic [31:0] w3_rot;
    logic [31:0] temp;
    logic [31:0] n0;
    logic [31:0] n1;
    logic [31:0] n2;
    // RotWord on the last word of the previous key
    w3_rot = {prev_q[23:0], prev_q[31:24]};
    // SubWord then round constant on the top byte
    temp = {aes_pkg::sbox(w3_rot[31:24]) ^ rcon_q, aes_pkg::sbox(w3_rot[23:16]),
            aes_pkg::sbox(w3_rot[15:8]), aes_pkg::sbox(w3_rot[7:0])};
    n0 = prev_q[127:96] ^ temp;
    n1 = prev_q[95:64] ^ n0;
    n2 = prev_q[63:32] ^ n1;
    next_key = {n0, n1, n2, prev_q[31:0] ^ n2};
  end

  // ======================================
  // sequencing
  // ======================================
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q <= 1'b0;
      cnt_q <= '0;
      key_expanded_out <= 1'b0;
    end else begin
      key_expanded_out <= 1'b0;
      if (init_in) begin
        busy_q <= 1'b1;
        cnt_q <= 4'd1;
      end else if (busy_q) begin
        if (cnt_q == aes_pkg::NUM_ROUNDS) begin
          // tenth key lands this edge
          busy_q <= 1'b0;
          cnt_q <= '0;
          key_expanded_out <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 4'd1;
        end
      end
    end
  end

  // key storage
  always_ff @(posedge clk_in) begin
    if (init_in) begin
      rk_q[0] <= key_in;
      prev_q <= key_in;
      rcon_q <= 8'h01;
    end else if (busy_q) begin
      rk_q[cnt_q] <= next_key;
      prev_q <= next_key;
      // 01 02 04 ... 80 1b 36
      rcon_q <= aes_pkg::xtime(rcon_q);
    end
  end

  assign key_out = rk_q[round_rd];

  // the core maps both datapath counters into 0..10
  a_round_rd_range: assert property (@(posedge clk_in) disable iff (rst_in)
    round_rd <= aes_pkg::NUM_ROUNDS)
    else $error("key index %0d out of range", round_rd);

endmodule

`default_nettype wire

//--- aes_encryption.sv
// ======================================
// AES-128 cipher, one round per cycle
// key_in must follow round_out with no delay
// result and valid pulse one edge after round ten
// ======================================

`timescale 1ns/10ps
`default_nettype none

module aes_encryption (
  input wire clk_in,
  input wire rst_in,
  input wire init_in,
  input wire [aes_pkg::BLOCK_W-1:0] data_in,
  input wire [aes_pkg::BLOCK_W-1:0] key_in,
  output logic [aes_pkg::ROUND_W-1:0] round_out,
  output logic [aes_pkg::BLOCK_W-1:0] data_out,
  output logic valid_out
);

  logic [aes_pkg::BLOCK_W-1:0] state_q;
  logic [aes_pkg::BLOCK_W-1:0] round_state;
  logic [aes_pkg::ROUND_W-1:0] round_q;
  logic busy_q;

  // MixColumns on one column, byte 0 on top
  function automatic logic [31:0] mix_column(input logic [31:0] col);
    logic [7:0] a [4];
    logic [7:0] res [4];
    for (int i = 0; i < 4; i++) begin
      a[i] = col[31-8*i -: 8];
    end
    // 2 3 1 1 rotated per row
    for (int i = 0; i < 4; i++) begin
      res[i] = aes_pkg::xtime(a[i]) ^ aes_pkg::xtime(a[(i+1)%4]) ^ a[(i+1)%4] ^
               a[(i+2)%4] ^ a[(i+3)%4];
    end
    return {res[0], res[1], res[2], res[3]};
  endfunction

  // ======================================
  // round function
  // ======================================
  always_comb begin
    logic [aes_pkg::BLOCK_W-1:0] sub_s;
    logic [aes_pkg::BLOCK_W-1:0] shift_s;
    logic [aes_pkg::BLOCK_W-1:0] mix_s;
    for (int i = 0; i < aes_pkg::NUM_BYTES; i++) begin
      sub_s[127-8*i -: 8] = aes_pkg::sbox(state_q[127-8*i -: 8]);
    end
    // row r moves left by r columns
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        shift_s[127-8*(r+4*c) -: 8] = sub_s[127-8*(r+4*((c+r)%4)) -: 8];
      end
    end
    for (int c = 0; c < 4; c++) begin
      mix_s[127-32*c -: 32] = mix_column(shift_s[127-32*c -: 32]);
    end
    // last round has no MixColumns
    round_state = ((round_q == aes_pkg::NUM_ROUNDS) ? shift_s : mix_s) ^ key_in;
  end

  // counter and busy flag
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q <= 1'b0;
      round_q <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= 1'b0;
      if (init_in) begin
        busy_q <= 1'b1;
        round_q <= 4'd1;
      end else if (busy_q) begin
        if (round_q == aes_pkg::NUM_ROUNDS) begin
          busy_q <= 1'b0;
          round_q <= '0;
          valid_out <= 1'b1;
        end else begin
          round_q <= round_q + 4'd1;
        end
      end
    end
  end

  // state register, initial AddRoundKey on init
  always_ff @(posedge clk_in) begin
    if (init_in) begin
      state_q <= data_in ^ key_in;
    end else if (busy_q) begin
      state_q <= round_state;
    end
  end

  assign round_out = round_q;
  assign data_out = state_q;

  a_valid_single: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out |=> !valid_out)
    else $error("encrypt valid held for two cycles");

  a_round_range: assert property (@(posedge clk_in) disable iff (rst_in)
    round_out <= aes_pkg::NUM_ROUNDS)
    else $error("encrypt round %0d past last round", round_out);

endmodule

`default_nettype wire

//--- aes_decryption.sv
// ======================================
// AES-128 inverse cipher, one round per cycle
// expects round key 10 on init, then keys 9 down to 0
// same counter and valid schedule as the cipher
// ======================================

`timescale 1ns/10ps
`default_nettype none

module aes_decryption (
  input wire clk_in,
  input wire rst_in,
  input wire init_in,
  input wire [aes_pkg::BLOCK_W-1:0] data_in,
  input wire [aes_pkg::BLOCK_W-1:0] key_in,
  output logic [aes_pkg::ROUND_W-1:0] round_out,
  output logic [aes_pkg::BLOCK_W-1:0] data_out,
  output logic valid_out
);

  logic [aes_pkg::BLOCK_W-1:0] state_q;
  logic [aes_pkg::BLOCK_W-1:0] round_state;
  logic [aes_pkg::ROUND_W-1:0] round_q;
  logic busy_q;

  // InvMixColumns on one column
  function automatic logic [31:0] inv_mix_column(input logic [31:0] col);
    logic [7:0] a [4];
    logic [7:0] res [4];
    for (int i = 0; i < 4; i++) begin
      a[i] = col[31-8*i -: 8];
    end
    // 0e 0b 0d 09 rotated per row
    for (int i = 0; i < 4; i++) begin
      res[i] = aes_pkg::gf_mul(a[i], 8'h0e) ^ aes_pkg::gf_mul(a[(i+1)%4], 8'h0b) ^
               aes_pkg::gf_mul(a[(i+2)%4], 8'h0d) ^ aes_pkg::gf_mul(a[(i+3)%4], 8'h09);
    end
    return {res[0], res[1], res[2], res[3]};
  endfunction

  // ======================================
  // inverse round function
  // ======================================
  always_comb begin
    logic [aes_pkg::BLOCK_W-1:0] shift_s;
    logic [aes_pkg::BLOCK_W-1:0] sub_s;
    logic [aes_pkg::BLOCK_W-1:0] add_s;
    logic [aes_pkg::BLOCK_W-1:0] mix_s;
    // row r moves right by r columns
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        shift_s[127-8*(r+4*c) -: 8] = state_q[127-8*(r+4*((c+4-r)%4)) -: 8];
      end
    end
    for (int i = 0; i < aes_pkg::NUM_BYTES; i++) begin
      sub_s[127-8*i -: 8] = aes_pkg::inv_sbox(shift_s[127-8*i -: 8]);
    end
    add_s = sub_s ^ key_in;
    for (int c = 0; c < 4; c++) begin
      mix_s[127-32*c -: 32] = inv_mix_column(add_s[127-32*c -: 32]);
    end
    // round ten ends on the AddRoundKey with key 0
    round_state = (round_q == aes_pkg::NUM_ROUNDS) ? add_s : mix_s;
  end

  // counter and busy flag
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q <= 1'b0;
      round_q <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= 1'b0;
      if (init_in) begin
        busy_q <= 1'b1;
        round_q <= 4'd1;
      end else if (busy_q) begin
        if (round_q == aes_pkg::NUM_ROUNDS) begin
          busy_q <= 1'b0;
          round_q <= '0;
          valid_out <= 1'b1;
        end else begin
          round_q <= round_q + 4'd1;
        end
      end
    end
  end

  // state register
  always_ff @(posedge clk_in) begin
    if (init_in) begin
      state_q <= data_in ^ key_in;
    end else if (busy_q) begin
      state_q <= round_state;
    end
  end

  assign round_out = round_q;
  assign data_out = state_q;

  a_valid_single: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out |=> !valid_out)
    else $error("decrypt valid held for two cycles");

endmodule

`default_nettype wire

//--- aes_core.sv
// ======================================
// iterative AES-128 core, one block at a time
// init_in is a one-cycle pulse, valid_out a one-cycle pulse
// result appears 22 edges after the init edge
// init during a run aborts it with no valid
// data_out holds the last result
// ======================================

`timescale 1ns/10ps
`default_nettype none

module aes_core (
  input wire clk_in,
  input wire rst_in,
  input wire aes_pkg::aes_mode_e mode_in,
  input wire init_in,
  input wire [aes_pkg::BLOCK_W-1:0] data_in,
  input wire [aes_pkg::BLOCK_W-1:0] key_in,
  output logic [aes_pkg::BLOCK_W-1:0] data_out,
  output logic valid_out
);

  aes_pkg::aes_job_t job_q;
  aes_pkg::aes_core_state_e state_q;
  // one-cycle start, a cycle after expansion ends
  logic start_q;
  logic launch;
  logic enc_init;
  logic dec_init;
  logic key_expanded;
  logic [aes_pkg::ROUND_W-1:0] enc_round;
  logic [aes_pkg::ROUND_W-1:0] dec_round;
  logic [aes_pkg::ROUND_W-1:0] key_idx;
  logic [aes_pkg::BLOCK_W-1:0] round_key;
  logic [aes_pkg::BLOCK_W-1:0] enc_data;
  logic [aes_pkg::BLOCK_W-1:0] dec_data;
  logic [aes_pkg::BLOCK_W-1:0] result;
  logic [aes_pkg::BLOCK_W-1:0] data_q;
  logic enc_valid;
  logic dec_valid;
  logic dp_valid;
  logic is_enc;

  assign is_enc = (job_q.mode == aes_pkg::AES_ENCRYPT);

  // ======================================
  // job capture and sequencer
  // ======================================
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      job_q <= '0;
    end else if (init_in) begin
      job_q.mode <= mode_in;
      job_q.data <= data_in;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state_q <= aes_pkg::CORE_IDLE;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (init_in) begin
        // new job wins over anything in flight
        state_q <= aes_pkg::CORE_EXPAND;
      end else begin
        case (state_q)
          aes_pkg::CORE_EXPAND: begin
            if (key_expanded) begin
              state_q <= aes_pkg::CORE_CIPHER;
              start_q <= 1'b1;
            end
          end
          aes_pkg::CORE_CIPHER: begin
            if (dp_valid) begin
              state_q <= aes_pkg::CORE_IDLE;
            end
          end
          default: state_q <= aes_pkg::CORE_IDLE;
        endcase
      end
    end
  end

  // start only the datapath of the captured mode
  assign launch = start_q & ~init_in;
  assign enc_init = launch & is_enc;
  assign dec_init = launch & ~is_enc;

  // decryption walks the key file from the top
  assign key_idx = is_enc ? enc_round : aes_pkg::NUM_ROUNDS - dec_round;

  // ======================================
  // submodules
  // ======================================
  aes_key_memory key_mem_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .init_in(init_in),
    .key_in(key_in),
    .round_rd(key_idx),
    .key_out(round_key),
    .key_expanded_out(key_expanded)
  );

  aes_encryption enc_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .init_in(enc_init),
    .data_in(job_q.data),
    .key_in(round_key),
    .round_out(enc_round),
    .data_out(enc_data),
    .valid_out(enc_valid)
  );

  aes_decryption dec_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .init_in(dec_init),
    .data_in(job_q.data),
    .key_in(round_key),
    .round_out(dec_round),
    .data_out(dec_data),
    .valid_out(dec_valid)
  );

  // ======================================
  // result
  // ======================================
  assign dp_valid = is_enc ? enc_valid : dec_valid;
  assign result = is_enc ? enc_data : dec_data;
  // a datapath finishing an aborted job is ignored outside CORE_CIPHER
  assign valid_out = dp_valid & (state_q == aes_pkg::CORE_CIPHER);

  // keep the result once the datapath moves on
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      data_q <= '0;
    end else if (valid_out) begin
      data_q <= result;
    end
  end

  assign data_out = valid_out ? result : data_q;

  a_valid_after_cipher: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out |-> $past(state_q) == aes_pkg::CORE_CIPHER)
    else $error("valid_out without a cipher run");

endmodule

`default_nettype wire

//--- tb_aes_core.sv
// ========================================
// directed testbench for the AES-128 core
// vectors from FIPS-197 appendix B and C.1
// outputs sampled on the falling edge
// stops at the first failed check
// ========================================

`timescale 1ns/10ps
`default_nettype none

module tb_aes_core;

  localparam int RESET_CYCLES = 16;
  localparam int LATENCY = 23;
  // 2 known answers, capture, restart (2), 40 round-trip jobs, plus idle windows
  localparam int NUM_JOBS = 48;
  localparam int CYCLE_LIMIT = RESET_CYCLES + 40 * NUM_JOBS;
  localparam logic [31:0] SEED = 32'h122a;

  // FIPS-197 C.1
  localparam logic [127:0] C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] C1_PLAIN = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] C1_CIPHER = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  // FIPS-197 appendix B
  localparam logic [127:0] B_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] B_PLAIN = 128'h3243f6a8885a308d313198a2e0370734;
  localparam logic [127:0] B_CIPHER = 128'h3925841d02dc09fbdc118597196a0b32;

  logic clk_in;
  logic rst_in;
  aes_pkg::aes_mode_e mode_in;
  logic init_in;
  logic [aes_pkg::BLOCK_W-1:0] data_in;
  logic [aes_pkg::BLOCK_W-1:0] key_in;
  logic [aes_pkg::BLOCK_W-1:0] data_out;
  logic valid_out;
  int cycle_count;

  aes_core aes_core_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .mode_in(mode_in),
    .init_in(init_in),
    .data_in(data_in),
    .key_in(key_in),
    .data_out(data_out),
    .valid_out(valid_out)
  );

  // 4 ns period
  initial clk_in = 1'b0;
  always #2 clk_in = ~clk_in;

  // watchdog
  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("run stopped: no progress after %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  // ========================================
  // helpers
  // ========================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped on a failed check");
  endtask

  task automatic check_block(input logic [aes_pkg::BLOCK_W-1:0] expected,
                             input logic [aes_pkg::BLOCK_W-1:0] actual, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("Error at %0t ns: %s, expected %h, got %h",
                          $time, what, expected, actual));
    end
  endtask

  task automatic check_mode(input aes_pkg::aes_mode_e expected,
                            input aes_pkg::aes_mode_e actual, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("Error at %0t ns: %s, expected %s, got %s",
                          $time, what, expected.name(), actual.name()));
    end
  endtask

  function automatic aes_pkg::aes_job_t make_job(input aes_pkg::aes_mode_e mode,
                                                 input logic [aes_pkg::BLOCK_W-1:0] data);
    aes_pkg::aes_job_t job;
    job.mode = mode;
    job.data = data;
    return job;
  endfunction

  // one init pulse, returns in the time step of the sampling edge
  task automatic drive_job(input aes_pkg::aes_job_t job, input logic [aes_pkg::BLOCK_W-1:0] key);
    @(posedge clk_in);
    mode_in <= job.mode;
    data_in <= job.data;
    key_in <= key;
    init_in <= 1'b1;
    @(posedge clk_in);
    init_in <= 1'b0;
  endtask

  // valid must show in the 23rd cycle after the sampling edge, not before
  task automatic wait_result(output logic [aes_pkg::BLOCK_W-1:0] data);
    int cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < LATENCY) begin
      @(negedge clk_in);
      cycles++;
      seen = valid_out;
    end
    if (!seen) begin
      abort_run($sformatf("no valid_out within %0d cycles of init_in", LATENCY));
    end else if (cycles != LATENCY) begin
      abort_run($sformatf("valid_out came after %0d cycles instead of %0d", cycles, LATENCY));
    end else begin
      data = data_out;
    end
  endtask

  task automatic run_job(input aes_pkg::aes_job_t job, input logic [aes_pkg::BLOCK_W-1:0] key,
                         output logic [aes_pkg::BLOCK_W-1:0] data);
    drive_job(job, key);
    wait_result(data);
  endtask

  // no valid for n cycles, data_out optionally held at a known value
  task automatic expect_quiet(input int n, input logic check_data,
                              input logic [aes_pkg::BLOCK_W-1:0] held);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_in);
      if (valid_out) begin
        abort_run($sformatf("unexpected valid_out at %0t ns", $time));
      end
      if (check_data) begin
        check_block(held, data_out, "held data_out");
      end
    end
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic idle_after_reset();
    expect_quiet(20, 1'b1, '0);
  endtask

  task automatic encrypt_known_answer();
    logic [aes_pkg::BLOCK_W-1:0] res;
    run_job(make_job(aes_pkg::AES_ENCRYPT, C1_PLAIN), C1_KEY, res);
    check_block(C1_CIPHER, res, "C.1 encryption");
  endtask

  task automatic decrypt_known_answer();
    logic [aes_pkg::BLOCK_W-1:0] res;
    run_job(make_job(aes_pkg::AES_DECRYPT, C1_CIPHER), C1_KEY, res);
    check_block(C1_PLAIN, res, "C.1 decryption");
  endtask

  // inputs move right after the sampling edge
  task automatic job_capture();
    logic [aes_pkg::BLOCK_W-1:0] res;
    aes_pkg::aes_mode_e dir;
    drive_job(make_job(aes_pkg::AES_ENCRYPT, C1_PLAIN), C1_KEY);
    mode_in <= aes_pkg::AES_DECRYPT;
    data_in <= ~C1_PLAIN;
    wait_result(res);
    // direction seen from the result
    dir = (res == C1_CIPHER) ? aes_pkg::AES_ENCRYPT : aes_pkg::AES_DECRYPT;
    check_mode(aes_pkg::AES_ENCRYPT, dir, "captured mode");
    check_block(C1_CIPHER, res, "captured job result");
  endtask

  // second init about 8 cycles into the first job
  task automatic restart_mid_run();
    logic [aes_pkg::BLOCK_W-1:0] res;
    drive_job(make_job(aes_pkg::AES_ENCRYPT, C1_PLAIN), C1_KEY);
    expect_quiet(8, 1'b0, '0);
    run_job(make_job(aes_pkg::AES_ENCRYPT, B_PLAIN), B_KEY, res);
    check_block(B_CIPHER, res, "restarted job result");
    // aborted job leaves no late pulse, result stays on data_out
    expect_quiet(30, 1'b1, B_CIPHER);
  endtask

  task automatic random_round_trip(input int count);
    logic [aes_pkg::BLOCK_W-1:0] key;
    logic [aes_pkg::BLOCK_W-1:0] plain;
    logic [aes_pkg::BLOCK_W-1:0] cipher;
    logic [aes_pkg::BLOCK_W-1:0] back;
    for (int i = 0; i < count; i++) begin
      key = {$urandom, $urandom, $urandom, $urandom};
      plain = {$urandom, $urandom, $urandom, $urandom};
      run_job(make_job(aes_pkg::AES_ENCRYPT, plain), key, cipher);
      run_job(make_job(aes_pkg::AES_DECRYPT, cipher), key, back);
      check_block(plain, back, $sformatf("round trip %0d", i));
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    void'($urandom(SEED));
    cycle_count = 0;
    rst_in = 1'b1;
    init_in = 1'b0;
    mode_in = aes_pkg::AES_ENCRYPT;
    data_in = '0;
    key_in = '0;
    repeat (RESET_CYCLES) @(posedge clk_in);
    rst_in <= 1'b0;
    idle_after_reset();
    encrypt_known_answer();
    decrypt_known_answer();
    job_capture();
    restart_mid_run();
    random_round_trip(20);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
aes_pkg.sv
aes_key_memory.sv
aes_encryption.sv
aes_decryption.sv
aes_core.sv
tb_aes_core.sv
